/* dcache.f */
dcache_pkg.sv
dcache_index_hash.sv
dcache_line_store.sv
dcache_ctrl.sv
dcache.sv
tb_dcache_props.sv
tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - dcache_index_hash.sv
  - dcache_line_store.sv
  - dcache_ctrl.sv
  - dcache.sv
  - target: test
    files:
      - tb_dcache_props.sv
      - tb_dcache.sv

/* tb_dcache.sv */
// Data cache testbench with a random-latency RAM model, a reference memory and an access table.
`timescale 1ns/1ps

module tb_dcache;

  import dcache_pkg::*;

  localparam int CLK_PERIOD = 4;

  typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_FLUSH} op_e;

  typedef struct packed {
    op_e   op;
    addr_t addr;
    mask_t mask;
    data_t data;
    logic  exp_hit;
  } step_t;

  logic     clk;
  logic     resetn;
  logic     flush_i;
  logic     cpu_valid_i;
  cpu_req_t cpu_req_i;
  logic     cpu_ready_o;
  data_t    cpu_rdata_o;
  logic     ram_valid_o;
  ram_req_t ram_req_o;
  logic     ram_ready_i;
  data_t    ram_rdata_i;

  step_t       steps[$];
  bit          steps_ready;
  data_t       ram_mem[addr_t];
  data_t       ref_mem[addr_t];
  logic [31:0] lfsr;
  int          ram_delay;
  bit          ram_busy;

  dcache i_dut (.*);

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic addr_t word_of(addr_t a);
    return {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  endfunction

  // Contents of never-written words.
  function automatic data_t init_word(addr_t a);
    return {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
  endfunction

  function automatic data_t ram_word(addr_t a);
    return ram_mem.exists(word_of(a)) ? ram_mem[word_of(a)] : init_word(word_of(a));
  endfunction

  function automatic data_t ref_word(addr_t a);
    return ref_mem.exists(word_of(a)) ? ref_mem[word_of(a)] : init_word(word_of(a));
  endfunction

  function automatic data_t store_bytes(data_t old_word, data_t new_word, mask_t mask);
    data_t bit_mask;
    for (int i = 0; i < LANES; i++) begin
      bit_mask[i*8 +: 8] = {8{mask[i]}};
    end
    return (old_word & ~bit_mask) | (new_word & bit_mask);
  endfunction

  // Tag folded in index-wide chunks, then raw ^ fold ^ ror(fold, 1).
  function automatic idx_t hash_index(addr_t a);
    tag_t t;
    idx_t fold;
    t    = a[ADDR_W-1 -: TAG_W];
    fold = '0;
    for (int k = 0; k < TAG_W; k += IDX_W) begin
      fold ^= idx_t'(t >> k);
    end
    return a[OFFSET_W +: IDX_W] ^ fold ^ ((fold >> 1) | (fold << (IDX_W - 1)));
  endfunction

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic random_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = (val << 1) | lfsr[0];
    end
  endtask

  task automatic report_failure();
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      report_failure();
    end
  endtask

  task automatic add_step(input op_e op, input addr_t addr, input mask_t mask,
                          input data_t data, input logic exp_hit);
    steps.push_back('{op, addr, mask, data, exp_hit});
  endtask

  task automatic build_table();
    addr_t a1;
    addr_t a2;
    addr_t a3;
    addr_t ca;
    addr_t cb;
    tag_t  cb_tag;
    a1 = 32'h0000_1040;
    a2 = 32'h0001_80c4;
    a3 = 32'h0020_0f10;
    ca = 32'h0004_2208;
    // Same hashed index as ca under another tag.
    cb_tag = ca[ADDR_W-1 -: TAG_W] ^ 21'h00_0123;
    cb = {cb_tag, hash_index(ca) ^ hash_index({cb_tag, {(IDX_W + OFFSET_W){1'b0}}}), 2'b00};
    add_step(OP_READ,  a1, 4'h0, 32'h0, 1'b0);
    add_step(OP_READ,  a1, 4'h0, 32'h0, 1'b1);
    add_step(OP_WRITE, a1, 4'hf, 32'hcafe_0001, 1'b1);
    add_step(OP_READ,  a1, 4'h0, 32'h0, 1'b1);
    add_step(OP_WRITE, a2, 4'h6, 32'h1122_3344, 1'b0);
    add_step(OP_READ,  a2, 4'h0, 32'h0, 1'b1);
    add_step(OP_WRITE, a3, 4'hf, 32'h0bad_f00d, 1'b0);
    add_step(OP_READ,  a3, 4'h0, 32'h0, 1'b0);
    add_step(OP_READ,  a3, 4'h0, 32'h0, 1'b1);
    add_step(OP_READ,  ca, 4'h0, 32'h0, 1'b0);
    add_step(OP_READ,  cb, 4'h0, 32'h0, 1'b0);
    add_step(OP_READ,  ca, 4'h0, 32'h0, 1'b0);
    add_step(OP_READ,  cb, 4'h0, 32'h0, 1'b0);
    add_step(OP_WRITE, cb, 4'h1, 32'h0000_00a5, 1'b1);
    add_step(OP_READ,  cb, 4'h0, 32'h0, 1'b1);
    add_step(OP_FLUSH, a1, 4'h0, 32'h0, 1'b0);
    add_step(OP_READ,  a1, 4'h0, 32'h0, 1'b0);
    add_step(OP_READ,  a2, 4'h0, 32'h0, 1'b0);
    add_step(OP_READ,  a2, 4'h0, 32'h0, 1'b1);
  endtask

  task automatic run_step(input step_t s);
    int    cycles;
    int    rd_cnt;
    int    wr_cnt;
    bit    ram_seen;
    data_t got;
    cycles   = 0;
    rd_cnt   = 0;
    wr_cnt   = 0;
    ram_seen = 1'b0;
    @(negedge clk);
    if (s.op == OP_FLUSH) begin
      flush_i = 1'b1;
      @(negedge clk);
      flush_i = 1'b0;
    end else begin
      cpu_valid_i     = 1'b1;
      cpu_req_i.addr  = s.addr;
      cpu_req_i.wmask = (s.op == OP_WRITE) ? s.mask : '0;
      cpu_req_i.wdata = s.data;
      do begin
        @(posedge clk);
        cycles++;
        ram_seen |= ram_valid_o;
        if (ram_valid_o && ram_ready_i) begin
          check_value("ram_req_o.addr", s.addr, ram_req_o.addr);
          if (ram_req_o.wmask == '0) begin
            rd_cnt++;
          end else begin
            wr_cnt++;
          end
        end
      end while (!cpu_ready_o);
      got = cpu_rdata_o;
      @(negedge clk);
      cpu_valid_i = 1'b0;
      check_value("ram_req_o read count",
                  !s.exp_hit && (s.op == OP_READ || !(&s.mask)), rd_cnt);
      check_value("ram_req_o write count", s.op == OP_WRITE, wr_cnt);
      if (s.op == OP_READ) begin
        check_value("cpu_rdata_o", ref_word(s.addr), got);
        if (s.exp_hit) begin
          check_value("ram_valid_o", 32'h0, ram_seen);
          check_value("cpu_ready_o hit latency", 32'd3, cycles);
        end
      end else begin
        ref_mem[word_of(s.addr)] = store_bytes(ref_word(s.addr), s.data, s.mask);
        check_value("ram word", ref_word(s.addr), ram_word(s.addr));
      end
    end
  endtask

  // RAM answers after 0 to 3 cycles and holds ready for one cycle.
  always @(negedge clk) begin
    if (ram_ready_i) begin
      ram_ready_i = 1'b0;
      ram_rdata_i = 'x;
      ram_busy    = 1'b0;
    end else if (ram_valid_o) begin
      if (!ram_busy) begin
        ram_busy = 1'b1;
        random_bits(2, ram_delay);
      end
      if (ram_delay == 0) begin
        ram_ready_i = 1'b1;
        ram_rdata_i = ram_word(ram_req_o.addr);
      end else begin
        ram_delay--;
      end
    end
  end

  always @(posedge clk) begin
    if (ram_valid_o && ram_ready_i && ram_req_o.wmask != '0) begin
      ram_mem[word_of(ram_req_o.addr)] =
        store_bytes(ram_word(ram_req_o.addr), ram_req_o.wdata, ram_req_o.wmask);
    end
  end

  initial begin
    wait (steps_ready);
    #((steps.size() * 20 + 8) * CLK_PERIOD);
    $display("Timeout: the access table did not complete in time");
    report_failure();
  end

  initial begin
    wait (i_dut.i_props.failures != 0);
    $display("A port assertion on the DUT failed");
    report_failure();
  end

  initial begin
    resetn      = 1'b0;
    flush_i     = 1'b0;
    cpu_valid_i = 1'b0;
    cpu_req_i   = '0;
    ram_ready_i = 1'b0;
    ram_rdata_i = '0;
    ram_busy    = 1'b0;
    ram_delay   = 0;
    lfsr        = 32'h9986_bba0;
    build_table();
    steps_ready = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    @(negedge clk);
    if (i_dut.i_props.failures != 0) begin
      $display("A port assertion on the DUT failed");
      report_failure();
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

/* tb_dcache_props.sv */
// Port-rule assertions for the data cache, bound into the cache top level.
`timescale 1ns/1ps

module tb_dcache_props (
  input logic                 clk,
  input logic                 resetn,
  input logic                 cpu_valid_i,
  input logic                 cpu_ready_i,
  input logic                 ram_valid_i,
  input dcache_pkg::ram_req_t ram_req_i,
  input logic                 ram_ready_i
);

  int failures = 0;

  // RAM request held while the RAM stalls.
  ram_req_stable: assert property (@(posedge clk) disable iff (!resetn)
    (ram_valid_i && !ram_ready_i) |=> (ram_valid_i && $stable(ram_req_i)))
  else begin
    failures++;
    $error("RAM request dropped or changed before ready");
  end

  cpu_ready_needs_valid: assert property (@(posedge clk) disable iff (!resetn)
    cpu_ready_i |-> cpu_valid_i)
  else begin
    failures++;
    $error("CPU ready raised without a CPU request");
  end

  quiet_after_reset: assert property (@(posedge clk)
    !resetn |=> (!cpu_ready_i && !ram_valid_i))
  else begin
    failures++;
    $error("CPU ready or RAM valid high right after reset");
  end

endmodule

bind dcache tb_dcache_props i_props (
  .clk         (clk),
  .resetn      (resetn),
  .cpu_valid_i (cpu_valid_i),
  .cpu_ready_i (cpu_ready_o),
  .ram_valid_i (ram_valid_o),
  .ram_req_i   (ram_req_o),
  .ram_ready_i (ram_ready_i)
);

/* dcache.sv */
// Direct-mapped write-through data cache top level between a CPU port and a RAM port.
`timescale 1ns/1ps

module dcache (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 flush_i,
  input  logic                 cpu_valid_i,
  input  dcache_pkg::cpu_req_t cpu_req_i,
  output logic                 cpu_ready_o,
  output dcache_pkg::data_t    cpu_rdata_o,
  output logic                 ram_valid_o,
  output dcache_pkg::ram_req_t ram_req_o,
  input  logic                 ram_ready_i,
  input  dcache_pkg::data_t    ram_rdata_i
);

  import dcache_pkg::*;

  idx_t  idx;
  tag_t  tag;
  logic  lookup_en;
  logic  fill_en;
  data_t fill_data;
  logic  hit;
  data_t line_rdata;

  dcache_index_hash i_hash (
    .addr_i (cpu_req_i.addr),
    .idx_o  (idx),
    .tag_o  (tag)
  );

  dcache_line_store i_store (
    .clk         (clk),
    .resetn      (resetn),
    .flush_i     (flush_i),
    .lookup_en_i (lookup_en),
    .fill_en_i   (fill_en),
    .idx_i       (idx),
    .tag_i       (tag),
    .fill_data_i (fill_data),
    .hit_o       (hit),
    .rdata_o     (line_rdata)
  );

  dcache_ctrl i_ctrl (
    .clk         (clk),
    .resetn      (resetn),
    .flush_i     (flush_i),
    .cpu_valid_i (cpu_valid_i),
    .cpu_req_i   (cpu_req_i),
    .cpu_ready_o (cpu_ready_o),
    .cpu_rdata_o (cpu_rdata_o),
    .ram_valid_o (ram_valid_o),
    .ram_req_o   (ram_req_o),
    .ram_ready_i (ram_ready_i),
    .ram_rdata_i (ram_rdata_i),
    .lookup_en_o (lookup_en),
    .fill_en_o   (fill_en),
    .fill_data_o (fill_data),
    .hit_i       (hit),
    .rdata_i     (line_rdata)
  );

endmodule

/* dcache_ctrl.sv */
// Cache controller: request FSM with write-through, partial-miss merge and allocate policy.
`timescale 1ns/1ps

module dcache_ctrl (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 flush_i,
  input  logic                 cpu_valid_i,
  input  dcache_pkg::cpu_req_t cpu_req_i,
  output logic                 cpu_ready_o,
  output dcache_pkg::data_t    cpu_rdata_o,
  output logic                 ram_valid_o,
  output dcache_pkg::ram_req_t ram_req_o,
  input  logic                 ram_ready_i,
  input  dcache_pkg::data_t    ram_rdata_i,
  output logic                 lookup_en_o,
  output logic                 fill_en_o,
  output dcache_pkg::data_t    fill_data_o,
  input  logic                 hit_i,
  input  dcache_pkg::data_t    rdata_i
);

  import dcache_pkg::*;

  state_e    state_q;
  state_e    state_d;
  req_kind_e kind;
  req_kind_e kind_q;
  logic      alloc_q;
  data_t     pending_q;

  always_comb begin
    if (cpu_req_i.wmask == '0) begin
      kind = REQ_READ;
    end else if (&cpu_req_i.wmask) begin
      kind = REQ_FULL_WRITE;
    end else begin
      kind = REQ_PART_WRITE;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (cpu_valid_i) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_LOOKUP: state_d = ST_CHECK;
      ST_CHECK: begin
        if (hit_i) begin
          state_d = (kind == REQ_READ) ? ST_IDLE : ST_WR_REQ;
        end else begin
          // Full stores skip the read and never allocate.
          state_d = (kind == REQ_FULL_WRITE) ? ST_WR_REQ : ST_RD_REQ;
        end
      end
      ST_RD_REQ: begin
        if (ram_ready_i) begin
          state_d = (kind_q == REQ_READ) ? ST_REFILL : ST_WR_REQ;
        end
      end
      ST_REFILL: state_d = ST_IDLE;
      ST_WR_REQ: begin
        if (ram_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn || flush_i) begin
      state_q <= ST_IDLE;
      kind_q  <= REQ_READ;
      alloc_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_CHECK) begin
        kind_q  <= kind;
        alloc_q <= hit_i || (kind == REQ_PART_WRITE);
      end
    end
  end

  // Pending word: store data, hit merge, or the captured RAM word.
  always_ff @(posedge clk) begin
    if (state_q == ST_CHECK) begin
      if (kind == REQ_FULL_WRITE) begin
        pending_q <= cpu_req_i.wdata;
      end else if (hit_i) begin
        pending_q <= merge_bytes(rdata_i, cpu_req_i.wdata, cpu_req_i.wmask);
      end
    end else if (state_q == ST_RD_REQ && ram_ready_i) begin
      // A read mask keeps every RAM byte.
      pending_q <= merge_bytes(ram_rdata_i, cpu_req_i.wdata, cpu_req_i.wmask);
    end
  end

  always_comb begin
    cpu_ready_o     = 1'b0;
    cpu_rdata_o     = '0;
    ram_valid_o     = 1'b0;
    ram_req_o.addr  = cpu_req_i.addr;
    ram_req_o.wmask = '0;
    ram_req_o.wdata = '0;
    lookup_en_o     = 1'b0;
    fill_en_o       = 1'b0;
    fill_data_o     = pending_q;
    case (state_q)
      ST_IDLE: lookup_en_o = cpu_valid_i;
      ST_CHECK: begin
        if (hit_i && kind == REQ_READ) begin
          cpu_ready_o = 1'b1;
          cpu_rdata_o = rdata_i;
        end
      end
      ST_RD_REQ: ram_valid_o = 1'b1;
      ST_REFILL: begin
        cpu_ready_o = 1'b1;
        cpu_rdata_o = pending_q;
        fill_en_o   = 1'b1;
      end
      ST_WR_REQ: begin
        ram_valid_o     = 1'b1;
        ram_req_o.wmask = cpu_req_i.wmask;
        ram_req_o.wdata = pending_q;
        if (ram_ready_i) begin
          cpu_ready_o = 1'b1;
          fill_en_o   = alloc_q;
        end
      end
      default: ;
    endcase
  end

endmodule

/* dcache_line_store.sv */
// Line store: valid, tag and data arrays with a two-stage lookup and registered hit compare.
`timescale 1ns/1ps

module dcache_line_store (
  input  logic              clk,
  input  logic              resetn,
  input  logic              flush_i,
  input  logic              lookup_en_i,
  input  logic              fill_en_i,
  input  dcache_pkg::idx_t  idx_i,
  input  dcache_pkg::tag_t  tag_i,
  input  dcache_pkg::data_t fill_data_i,
  output logic              hit_o,
  output dcache_pkg::data_t rdata_o
);

  import dcache_pkg::*;

  logic [NUM_LINES-1:0] valid_q;
  tag_t                 tag_mem  [NUM_LINES];
  data_t                data_mem [NUM_LINES];

  // First lookup stage.
  logic  rd_valid_q;
  tag_t  rd_tag_q;
  tag_t  cmp_tag_q;
  data_t rd_data_q;

  always_ff @(posedge clk) begin
    if (!resetn || flush_i) begin
      valid_q <= '0;
    end else if (fill_en_i) begin
      valid_q[idx_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_en_i) begin
      tag_mem[idx_i]  <= tag_i;
      data_mem[idx_i] <= fill_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn || flush_i) begin
      rd_valid_q <= 1'b0;
    end else if (lookup_en_i) begin
      rd_valid_q <= valid_q[idx_i];
    end
  end

  always_ff @(posedge clk) begin
    if (lookup_en_i) begin
      rd_tag_q  <= tag_mem[idx_i];
      rd_data_q <= data_mem[idx_i];
      cmp_tag_q <= tag_i;
    end
  end

  // Second stage: tag compare.
  always_ff @(posedge clk) begin
    if (!resetn || flush_i) begin
      hit_o   <= 1'b0;
      rdata_o <= '0;
    end else begin
      hit_o   <= rd_valid_q && (rd_tag_q == cmp_tag_q);
      rdata_o <= rd_data_q;
    end
  end

endmodule

/* dcache_index_hash.sv */
// Index hash: splits a CPU byte address into tag and fold-and-rotate hashed line index.
`timescale 1ns/1ps

module dcache_index_hash (
  input  dcache_pkg::addr_t addr_i,
  output dcache_pkg::idx_t  idx_o,
  output dcache_pkg::tag_t  tag_o
);

  import dcache_pkg::*;

  idx_t raw_idx;
  idx_t fold;

  assign raw_idx = addr_i[OFFSET_W +: IDX_W];
  assign tag_o   = addr_i[ADDR_W-1 -: TAG_W];

  // Fold the tag down to index width.
  always_comb begin
    fold = '0;
    for (int i = 0; i < TAG_W; i++) begin
      fold[i % IDX_W] = fold[i % IDX_W] ^ tag_o[i];
    end
  end

  // Raw index mixed with the fold and the fold rotated right by one.
  assign idx_o = raw_idx ^ fold ^ {fold[0], fold[IDX_W-1:1]};

endmodule

/* dcache_pkg.sv */
// Shared geometry, request types, controller enums and byte-merge helper for the data cache.
package dcache_pkg;

  // Geometry: one 32-bit word per line, 512 lines.
  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int LANES     = DATA_W / 8;
  localparam int NUM_LINES = 512;
  localparam int OFFSET_W  = $clog2(LANES);
  localparam int IDX_W     = $clog2(NUM_LINES);
  localparam int TAG_W     = ADDR_W - IDX_W - OFFSET_W;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [LANES-1:0]  mask_t;
  typedef logic [IDX_W-1:0]  idx_t;
  typedef logic [TAG_W-1:0]  tag_t;

  // CPU request, held by the CPU until ready. Zero mask is a read.
  typedef struct packed {
    addr_t addr;
    mask_t wmask;
    data_t wdata;
  } cpu_req_t;

  // RAM request, held while valid is high. Zero mask is a read.
  typedef struct packed {
    addr_t addr;
    mask_t wmask;
    data_t wdata;
  } ram_req_t;

  typedef enum logic [1:0] {
    REQ_READ,
    REQ_FULL_WRITE,
    REQ_PART_WRITE
  } req_kind_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_CHECK,
    ST_RD_REQ,
    ST_REFILL,
    ST_WR_REQ
  } state_e;

  // Per lane, new byte where the mask is set, old byte elsewhere.
  function automatic data_t merge_bytes(data_t old_word, data_t new_word, mask_t mask);
    data_t merged;
    for (int i = 0; i < LANES; i++) begin
      merged[i*8 +: 8] = mask[i] ? new_word[i*8 +: 8] : old_word[i*8 +: 8];
    end
    return merged;
  endfunction

endpackage
